/* design/core_isa_pkg.sv */
package core_isa_pkg;

    ////////////////////////////////////////////////////////////
    // RV32I major opcodes used by this core, bits [6:0]
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,  // LW
        OPC_OP_IMM = 7'b0010011,  // ADDI
        OPC_STORE  = 7'b0100011,  // SW
        OPC_OP     = 7'b0110011   // Register-register ALU ops
    } opcode_e;

    // funct3 for OP and OP_IMM
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,      // ADD, SUB, ADDI
        F3_SLT     = 3'b010,      // Signed less than
        F3_XOR     = 3'b100,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_e;

    localparam logic [6:0] FUNCT7_SUB = 7'b0100000;  // Selects SUB over ADD

    ////////////////////////////////////////////////////////////
    // Instruction field LSB positions
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;   // Also the I-type immediate
    localparam int FUNCT7_LSB = 25;   // Also the S-type immediate high part

endpackage

/* design/core_pipe_pkg.sv */
package core_pipe_pkg;

    typedef logic [31:0] word_t;      // Data word
    typedef logic [4:0]  reg_addr_t;  // GPR index

    // ALU operation
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,               // Also LW/SW address
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5                // Signed compare
    } alu_op_e;

    // Scratch pad access in MEM
    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    // Operand source in ID
    typedef enum logic [1:0] {
        FWD_GPR = 2'd0,               // Register file, incl. write-through
        FWD_EX  = 2'd1,               // ALU output of the ID/EX instruction
        FWD_MEM = 2'd2                // Load data or ALU result in MEM
    } fwd_sel_e;

endpackage

/* design/if_stage.sv */
`timescale 1ns/1ps

module if_stage #(
    parameter core_pipe_pkg::word_t RESET_PC = 32'h0000_0000  // First fetch address
) (
    input  logic                 clk,        // Clock
    input  logic                 rst_n,      // Sync reset
    input  logic                 stall,      // Load-use hold
    output core_pipe_pkg::word_t imem_addr,  // Current PC
    input  core_pipe_pkg::word_t imem_data,  // Word at PC, same cycle
    output core_pipe_pkg::word_t if_insn,    // IF/ID instruction
    output logic                 if_en       // IF/ID valid
);

    // PC doubles as the fetch address
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            imem_addr <= RESET_PC;
            if_en     <= 1'b0;               // No instruction yet
        end else if (!stall) begin
            imem_addr <= imem_addr + 32'd4;  // Sequential only
            if_en     <= 1'b1;
        end
    end

    // Instruction word held together with the PC
    always_ff @(posedge clk) begin
        if (!stall) begin
            if_insn <= imem_data;
        end
    end

endmodule

/* design/id_stage.sv */
`timescale 1ns/1ps

module id_stage (
    input  logic                     clk,             // Clock
    input  logic                     rst_n,           // Sync reset
    input  core_pipe_pkg::word_t     if_insn,         // IF/ID instruction
    input  logic                     if_en,           // IF/ID valid
    input  core_pipe_pkg::word_t     gpr_rs1_data,    // GPR read 1
    input  core_pipe_pkg::word_t     gpr_rs2_data,    // GPR read 2
    input  core_pipe_pkg::word_t     ex_fwd_data,     // ALU output
    input  core_pipe_pkg::word_t     mem_fwd_data,    // MEM stage result
    input  core_pipe_pkg::fwd_sel_e  rs1_fwd_sel,
    input  core_pipe_pkg::fwd_sel_e  rs2_fwd_sel,
    input  logic                     ld_hazard,       // Insert bubble
    output core_pipe_pkg::reg_addr_t rs1_addr,
    output core_pipe_pkg::reg_addr_t rs2_addr,
    output logic                     rs1_used,        // rs1 is a real source
    output logic                     rs2_used,        // rs2 is a real source
    output logic                     id_en,           // ID/EX valid
    output core_pipe_pkg::alu_op_e   id_alu_op,
    output core_pipe_pkg::word_t     id_alu_in_0,
    output core_pipe_pkg::word_t     id_alu_in_1,
    output core_pipe_pkg::mem_op_e   id_mem_op,
    output core_pipe_pkg::word_t     id_mem_wr_data,  // Store data
    output core_pipe_pkg::reg_addr_t id_rd_addr,
    output logic                     id_gpr_we
);
    import core_isa_pkg::*;
    import core_pipe_pkg::*;

    opcode_e   opcode;
    funct3_e   funct3;
    reg_addr_t rd_addr;
    word_t     i_imm;
    word_t     s_imm;
    word_t     imm;
    word_t     rs1_val;
    word_t     rs2_val;
    alu_op_e   alu_op;
    mem_op_e   mem_op;
    logic      use_imm;
    logic      gpr_we;

    function automatic word_t fwd_mux(fwd_sel_e sel, word_t gpr_data, word_t ex_data,
                                      word_t mem_data);
        case (sel)
            FWD_EX:  return ex_data;
            FWD_MEM: return mem_data;
            default: return gpr_data;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Fields and immediates
    assign opcode   = opcode_e'(if_insn[6:0]);
    assign funct3   = funct3_e'(if_insn[FUNCT3_LSB +: 3]);
    assign rd_addr  = if_insn[RD_LSB +: 5];
    assign rs1_addr = if_insn[RS1_LSB +: 5];
    assign rs2_addr = if_insn[RS2_LSB +: 5];
    assign i_imm    = {{20{if_insn[31]}}, if_insn[RS2_LSB +: 12]};
    assign s_imm    = {{20{if_insn[31]}}, if_insn[FUNCT7_LSB +: 7], if_insn[RD_LSB +: 5]};

    // Operands after forwarding
    assign rs1_val = fwd_mux(rs1_fwd_sel, gpr_rs1_data, ex_fwd_data, mem_fwd_data);
    assign rs2_val = fwd_mux(rs2_fwd_sel, gpr_rs2_data, ex_fwd_data, mem_fwd_data);

    ////////////////////////////////////////////////////////////
    // Decoder
    always_comb begin
        alu_op   = ALU_ADD;                 // Base plus offset for LW/SW
        mem_op   = MEM_NONE;
        use_imm  = 1'b1;
        imm      = i_imm;
        gpr_we   = 1'b0;
        rs1_used = 1'b0;
        rs2_used = 1'b0;
        if (if_en) begin
            case (opcode)
                OPC_OP: begin
                    rs1_used = 1'b1;
                    rs2_used = 1'b1;
                    use_imm  = 1'b0;
                    gpr_we   = 1'b1;
                    case (funct3)
                        F3_ADD_SUB: alu_op = (if_insn[FUNCT7_LSB +: 7] == FUNCT7_SUB) ?
                                             ALU_SUB : ALU_ADD;
                        F3_SLT:     alu_op = ALU_SLT;
                        F3_XOR:     alu_op = ALU_XOR;
                        F3_OR:      alu_op = ALU_OR;
                        F3_AND:     alu_op = ALU_AND;
                        default:    gpr_we = 1'b0;  // Unsupported op, bubble
                    endcase
                end
                OPC_OP_IMM: begin
                    rs1_used = 1'b1;
                    gpr_we   = (funct3 == F3_ADD_SUB);  // ADDI only
                end
                OPC_LOAD: begin
                    rs1_used = 1'b1;
                    mem_op   = MEM_LOAD;
                    gpr_we   = 1'b1;
                end
                OPC_STORE: begin
                    rs1_used = 1'b1;
                    rs2_used = 1'b1;
                    mem_op   = MEM_STORE;
                    imm      = s_imm;
                end
                default: ;                          // Unknown opcode retires empty
            endcase
        end
        if (rd_addr == 5'd0) begin
            gpr_we = 1'b0;                          // x0 is never written
        end
    end

    ////////////////////////////////////////////////////////////
    // ID/EX register
    always_ff @(posedge clk) begin
        if (!rst_n || ld_hazard) begin              // Bubble on load-use
            id_en     <= 1'b0;
            id_gpr_we <= 1'b0;
            id_mem_op <= MEM_NONE;
        end else begin
            id_en     <= if_en;
            id_gpr_we <= gpr_we;
            id_mem_op <= mem_op;
        end
    end

    always_ff @(posedge clk) begin
        id_alu_op      <= alu_op;
        id_alu_in_0    <= rs1_val;
        id_alu_in_1    <= use_imm ? imm : rs2_val;
        id_mem_wr_data <= rs2_val;
        id_rd_addr     <= rd_addr;
    end

endmodule

/* design/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage (
    input  logic                     clk,             // Clock
    input  logic                     rst_n,           // Sync reset
    input  logic                     id_en,           // ID/EX valid
    input  core_pipe_pkg::alu_op_e   id_alu_op,
    input  core_pipe_pkg::word_t     id_alu_in_0,
    input  core_pipe_pkg::word_t     id_alu_in_1,
    input  core_pipe_pkg::mem_op_e   id_mem_op,
    input  core_pipe_pkg::word_t     id_mem_wr_data,
    input  core_pipe_pkg::reg_addr_t id_rd_addr,
    input  logic                     id_gpr_we,
    output core_pipe_pkg::word_t     ex_fwd_data,     // ALU result to ID
    output logic                     ex_en,           // EX/MEM valid
    output core_pipe_pkg::mem_op_e   ex_mem_op,
    output core_pipe_pkg::word_t     ex_mem_wr_data,
    output core_pipe_pkg::reg_addr_t ex_rd_addr,
    output logic                     ex_gpr_we,
    output core_pipe_pkg::word_t     ex_out           // ALU result or address
);
    import core_pipe_pkg::*;

    // ALU
    always_comb begin
        case (id_alu_op)
            ALU_SUB: ex_fwd_data = id_alu_in_0 - id_alu_in_1;
            ALU_AND: ex_fwd_data = id_alu_in_0 & id_alu_in_1;
            ALU_OR:  ex_fwd_data = id_alu_in_0 | id_alu_in_1;
            ALU_XOR: ex_fwd_data = id_alu_in_0 ^ id_alu_in_1;
            ALU_SLT: ex_fwd_data = {31'b0, $signed(id_alu_in_0) < $signed(id_alu_in_1)};
            default: ex_fwd_data = id_alu_in_0 + id_alu_in_1;  // ALU_ADD
        endcase
    end

    // EX/MEM control
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_en     <= 1'b0;
            ex_gpr_we <= 1'b0;
            ex_mem_op <= MEM_NONE;
        end else begin
            ex_en     <= id_en;
            ex_gpr_we <= id_en & id_gpr_we;             // Bubble writes nothing
            ex_mem_op <= id_en ? id_mem_op : MEM_NONE;  // Nor touches memory
        end
    end

    // EX/MEM payload
    always_ff @(posedge clk) begin
        ex_out         <= ex_fwd_data;
        ex_mem_wr_data <= id_mem_wr_data;
        ex_rd_addr     <= id_rd_addr;
    end

endmodule

/* design/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage #(
    parameter int SPM_DEPTH = 256  // Words, power of two
) (
    input  logic                         clk,             // Clock
    input  logic                         rst_n,           // Sync reset
    input  logic                         ex_en,           // EX/MEM valid
    input  core_pipe_pkg::mem_op_e       ex_mem_op,
    input  core_pipe_pkg::word_t         ex_mem_wr_data,
    input  core_pipe_pkg::reg_addr_t     ex_rd_addr,
    input  logic                         ex_gpr_we,
    input  core_pipe_pkg::word_t         ex_out,          // ALU result or address
    input  core_pipe_pkg::word_t         spm_rd_data,     // Combinational read
    output logic [$clog2(SPM_DEPTH)-1:0] spm_addr,        // Word index
    output logic                         spm_we,
    output core_pipe_pkg::word_t         spm_wr_data,
    output core_pipe_pkg::word_t         mem_fwd_data,    // Result to ID
    output logic                         mem_gpr_we,      // MEM/WB write enable
    output core_pipe_pkg::reg_addr_t     mem_rd_addr,
    output core_pipe_pkg::word_t         mem_out
);
    import core_pipe_pkg::*;

    // Scratch pad access
    assign spm_addr    = ex_out[2 +: $bits(spm_addr)];           // Wraps modulo depth
    assign spm_we      = ex_en && (ex_mem_op == MEM_STORE);
    assign spm_wr_data = ex_mem_wr_data;

    // Load data or ALU result
    assign mem_fwd_data = (ex_mem_op == MEM_LOAD) ? spm_rd_data : ex_out;

    // MEM/WB register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_gpr_we <= 1'b0;
        end else begin
            mem_gpr_we <= ex_en & ex_gpr_we;
        end
    end

    always_ff @(posedge clk) begin
        mem_rd_addr <= ex_rd_addr;
        mem_out     <= mem_fwd_data;
    end

endmodule

/* design/gpr.sv */
`timescale 1ns/1ps

module gpr (
    input  logic                     clk,       // Clock
    input  core_pipe_pkg::reg_addr_t rs1_addr,  // Read port 1
    input  core_pipe_pkg::reg_addr_t rs2_addr,  // Read port 2
    input  logic                     we,        // Writeback enable
    input  core_pipe_pkg::reg_addr_t wr_addr,
    input  core_pipe_pkg::word_t     wr_data,
    output core_pipe_pkg::word_t     rs1_data,
    output core_pipe_pkg::word_t     rs2_data
);
    import core_pipe_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Same-cycle write passes straight through
    assign rs1_data = (we && (wr_addr == rs1_addr)) ? wr_data : regs[rs1_addr];
    assign rs2_data = (we && (wr_addr == rs2_addr)) ? wr_data : regs[rs2_addr];

endmodule

/* design/spm.sv */
`timescale 1ns/1ps

module spm #(
    parameter int SPM_DEPTH = 256  // Words, power of two
) (
    input  logic                         clk,      // Clock
    input  logic [$clog2(SPM_DEPTH)-1:0] addr,     // Word index
    input  logic                         we,       // Store
    input  core_pipe_pkg::word_t         wr_data,
    output core_pipe_pkg::word_t         rd_data   // Combinational read
);
    import core_pipe_pkg::*;

    word_t mem [SPM_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wr_data;
        end
    end

    assign rd_data = mem[addr];

endmodule

/* design/pipe_ctrl.sv */
`timescale 1ns/1ps

module pipe_ctrl (
    input  core_pipe_pkg::reg_addr_t rs1_addr,     // ID sources
    input  core_pipe_pkg::reg_addr_t rs2_addr,
    input  logic                     rs1_used,
    input  logic                     rs2_used,
    input  core_pipe_pkg::reg_addr_t id_rd_addr,   // Producer in ID/EX
    input  logic                     id_gpr_we,
    input  core_pipe_pkg::mem_op_e   id_mem_op,
    input  core_pipe_pkg::reg_addr_t ex_rd_addr,   // Producer in EX/MEM
    input  logic                     ex_gpr_we,
    output core_pipe_pkg::fwd_sel_e  rs1_fwd_sel,
    output core_pipe_pkg::fwd_sel_e  rs2_fwd_sel,
    output logic                     ld_hazard     // Stall IF, bubble into EX
);
    import core_pipe_pkg::*;

    logic id_rs1_hit;
    logic id_rs2_hit;
    logic ex_rs1_hit;
    logic ex_rs2_hit;

    // Address matches against writing producers
    assign id_rs1_hit = id_gpr_we && (id_rd_addr == rs1_addr);
    assign id_rs2_hit = id_gpr_we && (id_rd_addr == rs2_addr);
    assign ex_rs1_hit = ex_gpr_we && (ex_rd_addr == rs1_addr);
    assign ex_rs2_hit = ex_gpr_we && (ex_rd_addr == rs2_addr);

    ////////////////////////////////////////////////////////////
    // Youngest producer wins, MEM/WB covered by GPR write-through
    assign rs1_fwd_sel = id_rs1_hit ? FWD_EX : (ex_rs1_hit ? FWD_MEM : FWD_GPR);
    assign rs2_fwd_sel = id_rs2_hit ? FWD_EX : (ex_rs2_hit ? FWD_MEM : FWD_GPR);

    // Load result not ready until MEM
    assign ld_hazard = (id_mem_op == MEM_LOAD) &&
                       ((rs1_used && id_rs1_hit) || (rs2_used && id_rs2_hit));

endmodule

/* design/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top #(
    parameter core_pipe_pkg::word_t RESET_PC  = 32'h0000_0000,  // First fetch address
    parameter int                   SPM_DEPTH = 256             // Data words, power of two
) (
    input  logic                     clk,          // Clock
    input  logic                     rst_n,        // Sync reset, active low
    output core_pipe_pkg::word_t     imem_addr,    // Fetch address
    input  core_pipe_pkg::word_t     imem_data,    // Instruction, same cycle
    output logic                     mem_gpr_we,   // Writeback valid
    output core_pipe_pkg::reg_addr_t mem_rd_addr,  // Writeback register
    output core_pipe_pkg::word_t     mem_out       // Writeback data
);
    import core_pipe_pkg::*;

    ////////////////////////////////////////////////////////////
    // IF/ID and decode side
    word_t     if_insn;
    logic      if_en;
    reg_addr_t rs1_addr, rs2_addr;
    logic      rs1_used, rs2_used;
    word_t     gpr_rs1_data, gpr_rs2_data;
    fwd_sel_e  rs1_fwd_sel, rs2_fwd_sel;
    logic      ld_hazard;                           // Load-use stall
    // ID/EX
    logic      id_en, id_gpr_we;
    alu_op_e   id_alu_op;
    word_t     id_alu_in_0, id_alu_in_1, id_mem_wr_data;
    mem_op_e   id_mem_op;
    reg_addr_t id_rd_addr;
    // EX/MEM
    logic      ex_en, ex_gpr_we;
    mem_op_e   ex_mem_op;
    word_t     ex_mem_wr_data, ex_out;
    reg_addr_t ex_rd_addr;
    word_t     ex_fwd_data, mem_fwd_data;           // Forward paths into ID
    // Scratch pad
    logic [$clog2(SPM_DEPTH)-1:0] spm_addr;
    logic      spm_we;
    word_t     spm_wr_data, spm_rd_data;

    ////////////////////////////////////////////////////////////
    // Pipeline stages
    if_stage #(.RESET_PC(RESET_PC)) if_stage (
        .stall (ld_hazard),                         // Hold PC and IF/ID
        .*
    );

    id_stage id_stage (.*);

    ex_stage ex_stage (.*);

    mem_stage #(.SPM_DEPTH(SPM_DEPTH)) mem_stage (.*);

    pipe_ctrl pipe_ctrl (.*);

    ////////////////////////////////////////////////////////////
    // Storage
    gpr gpr (
        .rs1_data (gpr_rs1_data),
        .rs2_data (gpr_rs2_data),
        .we       (mem_gpr_we),                     // Written from MEM/WB
        .wr_addr  (mem_rd_addr),
        .wr_data  (mem_out),
        .*
    );

    spm #(.SPM_DEPTH(SPM_DEPTH)) spm (
        .clk     (clk),
        .addr    (spm_addr),
        .we      (spm_we),
        .wr_data (spm_wr_data),
        .rd_data (spm_rd_data)
    );

endmodule

/* tests/cpu_top_tb.sv */
`timescale 1ns/1ps

module cpu_top_tb;
    import core_isa_pkg::*;
    import core_pipe_pkg::*;

    localparam word_t       RESET_PC   = 32'h0000_0000;
    localparam int          SPM_DEPTH  = 256;
    localparam int          MAX_CYCLES = 1000;          // ~150 insns at 2 cycles plus drain
    localparam word_t       NOP_INSN   = 32'h0000_0013; // ADDI x0 x0 0
    localparam logic [11:0] RND_BASE   = 12'h200;       // Random test data window

    logic      clk;
    logic      rst_n;
    word_t     imem_addr;
    word_t     imem_data;
    logic      mem_gpr_we;
    reg_addr_t mem_rd_addr;
    word_t     mem_out;

    word_t     imem [256];                              // Program image
    int        prog_len;
    word_t     ref_regs [32];                           // Architectural state
    word_t     ref_mem [int];                           // Word index to value
    reg_addr_t exp_addr [$];                            // Pending writebacks in order
    word_t     exp_data [$];
    int        cycles;

    cpu_top #(.RESET_PC(RESET_PC), .SPM_DEPTH(SPM_DEPTH)) dut (.*);

    // Past the program end the core sees NOPs
    assign imem_data = ((imem_addr >> 2) < prog_len) ? imem[imem_addr[9:2]] : NOP_INSN;

    always #5 clk = ~clk;                               // 10 ns period

    ////////////////////////////////////////////////////////////
    // Failure reporting and compares
    task automatic stop_with_failure(string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(string name, word_t actual, word_t expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("ERROR at %0d ns: %s expected 0x%08h, got 0x%08h",
                                        $time, name, expected, actual));
        end
    endtask

    task automatic check_reg_addr(string name, reg_addr_t actual, reg_addr_t expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("ERROR at %0d ns: %s expected x%0d, got x%0d",
                                        $time, name, expected, actual));
        end
    endtask

    task automatic check_flag(string name, logic actual, logic expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("ERROR at %0d ns: %s expected %b, got %b",
                                        $time, name, expected, actual));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Assembler with in-order reference model
    function automatic word_t sext12(logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic int word_index(word_t addr);
        return int'((addr >> 2) % SPM_DEPTH);           // Byte address to SPM word
    endfunction

    function automatic reg_addr_t pick_reg(logic [7:0] v);
        return reg_addr_t'(v % 8'd7 + 8'd1);            // x1 to x7 only
    endfunction

    function automatic funct3_e pick_funct3(logic [2:0] v);
        case (v % 3'd5)
            3'd0:    return F3_ADD_SUB;
            3'd1:    return F3_SLT;
            3'd2:    return F3_XOR;
            3'd3:    return F3_OR;
            default: return F3_AND;
        endcase
    endfunction

    task automatic append_insn(word_t insn);
        imem[prog_len[7:0]] = insn;
        prog_len++;
    endtask

    task automatic expect_wb(reg_addr_t rd, word_t value);
        if (rd != 5'd0) begin                           // x0 writes never retire
            ref_regs[rd] = value;
            exp_addr.push_back(rd);
            exp_data.push_back(value);
        end
    endtask

    task automatic alu_rr(funct3_e f3, logic sub, reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
        word_t      a;
        word_t      b;
        word_t      res;
        logic [6:0] f7;
        a  = ref_regs[rs1];
        b  = ref_regs[rs2];
        f7 = (sub && f3 == F3_ADD_SUB) ? FUNCT7_SUB : 7'd0;
        case (f3)
            F3_ADD_SUB: res = (f7 == FUNCT7_SUB) ? a - b : a + b;
            F3_SLT:     res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_XOR:     res = a ^ b;
            F3_OR:      res = a | b;
            default:    res = a & b;
        endcase
        append_insn({f7, rs2, rs1, f3, rd, OPC_OP});
        expect_wb(rd, res);
    endtask

    task automatic add_imm(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
        append_insn({imm, rs1, F3_ADD_SUB, rd, OPC_OP_IMM});
        expect_wb(rd, ref_regs[rs1] + sext12(imm));
    endtask

    task automatic load_word(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
        int idx;
        idx = word_index(ref_regs[rs1] + sext12(imm));
        if (!ref_mem.exists(idx)) begin
            stop_with_failure($sformatf("Test program loads SPM word %0d before storing it", idx));
        end
        append_insn({imm, rs1, 3'b010, rd, OPC_LOAD});
        expect_wb(rd, ref_mem[idx]);
    endtask

    task automatic store_word(reg_addr_t rs2, reg_addr_t rs1, logic [11:0] imm);
        int idx;
        idx = word_index(ref_regs[rs1] + sext12(imm));
        ref_mem[idx] = ref_regs[rs2];
        append_insn({imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE});
    endtask

    ////////////////////////////////////////////////////////////
    // Program sequencing
    task automatic load_start();
        @(posedge clk);
        #1;
        rst_n    = 1'b0;                                // Hold core while imem changes
        prog_len = 0;
    endtask

    task automatic run_to_completion();
        int waited;
        waited = 0;
        repeat (5) begin
            @(posedge clk);
            #1;
            check_flag("mem_gpr_we", mem_gpr_we, 1'b0);  // Quiet in reset
            check_word("imem_addr", imem_addr, RESET_PC); // PC back at start
        end
        rst_n = 1'b1;
        while (exp_data.size() != 0 && waited < 2 * prog_len + 20) begin
            @(posedge clk);
            waited++;
        end
        if (exp_data.size() != 0) begin
            stop_with_failure($sformatf("%0d expected writebacks never arrived", exp_data.size()));
        end
        repeat (8) @(posedge clk);                      // Stray writebacks hit the monitor
    endtask

    // Writeback monitor samples mid-cycle where outputs are settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (mem_gpr_we === 1'b1) begin
                if (exp_data.size() == 0) begin
                    stop_with_failure($sformatf("Unexpected writeback to x%0d at %0d ns",
                                                mem_rd_addr, $time));
                end else begin
                    check_reg_addr("mem_rd_addr", mem_rd_addr, exp_addr.pop_front());
                    check_word("mem_out", mem_out, exp_data.pop_front());
                end
            end else if (mem_gpr_we !== 1'b0) begin
                stop_with_failure("mem_gpr_we is unknown outside reset");
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            stop_with_failure($sformatf("Timeout after %0d cycles", cycles));
        end
    end

    ////////////////////////////////////////////////////////////
    // Directed tests
    task automatic reset_quiet();
        load_start();
        repeat (4) add_imm(5'd0, 5'd0, 12'h000);
        add_imm(5'd1, 5'd0, 12'h001);                   // First real retirement
        run_to_completion();
    endtask

    task automatic alu_independent();
        load_start();
        add_imm(5'd1, 5'd0, 12'hff9);                   // -7
        add_imm(5'd2, 5'd0, 12'h003);
        add_imm(5'd3, 5'd0, 12'hf9c);                   // -100
        add_imm(5'd4, 5'd0, 12'h7ff);
        repeat (3) add_imm(5'd0, 5'd0, 12'h000);        // Seeds settle in GPR
        alu_rr(F3_ADD_SUB, 1'b0, 5'd10, 5'd1, 5'd2);
        alu_rr(F3_ADD_SUB, 1'b1, 5'd11, 5'd3, 5'd1);
        alu_rr(F3_AND, 1'b0, 5'd12, 5'd1, 5'd4);
        alu_rr(F3_OR, 1'b0, 5'd13, 5'd3, 5'd2);
        alu_rr(F3_XOR, 1'b0, 5'd14, 5'd1, 5'd3);
        alu_rr(F3_SLT, 1'b0, 5'd15, 5'd3, 5'd1);        // Both negative
        alu_rr(F3_SLT, 1'b0, 5'd16, 5'd2, 5'd1);
        run_to_completion();
    endtask

    task automatic forwarding_chains();
        load_start();
        add_imm(5'd1, 5'd0, 12'd10);
        add_imm(5'd2, 5'd1, 12'd5);                     // EX forward
        alu_rr(F3_ADD_SUB, 1'b0, 5'd3, 5'd2, 5'd1);     // EX and MEM forward
        add_imm(5'd0, 5'd0, 12'h000);
        alu_rr(F3_ADD_SUB, 1'b1, 5'd4, 5'd3, 5'd2);     // MEM and write-through
        add_imm(5'd5, 5'd0, 12'hfff);
        alu_rr(F3_XOR, 1'b0, 5'd6, 5'd4, 5'd5);
        alu_rr(F3_ADD_SUB, 1'b0, 5'd6, 5'd6, 5'd6);
        alu_rr(F3_ADD_SUB, 1'b0, 5'd6, 5'd6, 5'd6);
        alu_rr(F3_SLT, 1'b0, 5'd7, 5'd6, 5'd4);
        add_imm(5'd0, 5'd1, 12'h063);                   // Dropped without writeback
        alu_rr(F3_OR, 1'b0, 5'd8, 5'd0, 5'd1);          // x0 still zero
        run_to_completion();
    endtask

    task automatic memory_access();
        load_start();
        add_imm(5'd1, 5'd0, 12'h123);
        add_imm(5'd2, 5'd0, 12'hbaa);
        add_imm(5'd5, 5'd0, 12'(SPM_DEPTH * 4));        // One SPM span up
        store_word(5'd1, 5'd0, 12'h008);
        store_word(5'd2, 5'd0, 12'h00c);
        load_word(5'd3, 5'd0, 12'h008);
        load_word(5'd4, 5'd0, 12'h00c);
        store_word(5'd2, 5'd0, 12'h008);                // Overwrite same word
        load_word(5'd6, 5'd0, 12'h008);
        store_word(5'd1, 5'd5, 12'h014);                // Wraps onto word 5
        load_word(5'd7, 5'd0, 12'h014);
        load_word(5'd8, 5'd5, 12'h00c);                 // Wraps onto word 3
        run_to_completion();
    endtask

    task automatic load_use();
        load_start();
        add_imm(5'd1, 5'd0, 12'd77);
        store_word(5'd1, 5'd0, 12'h020);
        load_word(5'd2, 5'd0, 12'h020);
        alu_rr(F3_ADD_SUB, 1'b0, 5'd3, 5'd2, 5'd2);     // Both sources stall
        load_word(5'd4, 5'd0, 12'h020);
        add_imm(5'd5, 5'd4, 12'h001);
        load_word(5'd6, 5'd0, 12'h020);
        store_word(5'd6, 5'd0, 12'h024);                // Store data waits
        load_word(5'd7, 5'd0, 12'h024);
        alu_rr(F3_ADD_SUB, 1'b1, 5'd1, 5'd7, 5'd3);
        run_to_completion();
    endtask

    task automatic random_program();
        integer      seed;
        word_t       r;
        int          i;
        logic [11:0] ofs;
        seed = 32'hf950_abd7;
        load_start();
        for (i = 1; i < 8; i++) begin
            r = $random(seed);
            add_imm(reg_addr_t'(i), 5'd0, r[11:0]);
        end
        for (i = 0; i < 8; i++) begin                   // Every word loads may touch
            store_word(reg_addr_t'(i % 7 + 1), 5'd0, RND_BASE + 12'(4 * i));
        end
        for (i = 0; i < 60; i++) begin
            r   = $random(seed);
            ofs = RND_BASE + {7'd0, r[29:27], 2'b00};
            case (r[26:24])
                3'd3, 3'd4: add_imm(pick_reg(r[7:0]), pick_reg(r[15:8]), r[31:20]);
                3'd5, 3'd7: load_word(pick_reg(r[7:0]), 5'd0, ofs);
                3'd6:       store_word(pick_reg(r[23:16]), 5'd0, ofs);
                default:    alu_rr(pick_funct3(r[30:28]), r[31], pick_reg(r[7:0]),
                                   pick_reg(r[15:8]), pick_reg(r[23:16]));
            endcase
        end
        run_to_completion();
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        prog_len    = 0;
        cycles      = 0;
        ref_regs[0] = '0;                               // x0 in the model
        reset_quiet();
        alu_independent();
        forwarding_chains();
        memory_access();
        load_use();
        random_program();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* compile.f */
design/core_isa_pkg.sv
design/core_pipe_pkg.sv
design/if_stage.sv
design/id_stage.sv
design/ex_stage.sv
design/mem_stage.sv
design/gpr.sv
design/spm.sv
design/pipe_ctrl.sv
design/cpu_top.sv
tests/cpu_top_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module cpu_top_tb -f compile.f -o cpu_top_sim

# The log decides the result, not the exit status
./obj_dir/cpu_top_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
